/* Bender.yml */
package:
  name: uno_player

sources:
  - files:
      - uno_pkg.sv
      - uno_hand_if.sv
      - uno_hand_store.sv
      - uno_card_picker.sv
      - uno_turn_fsm.sv
      - uno_player.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_uno_player.sv

/* tb_uno_model.svh */
`ifndef TB_UNO_MODEL_SVH
`define TB_UNO_MODEL_SVH

// reference hand kept as copy counts
int m_cnt [4][13];
int m_wild;
int m_wild4;
int m_num;
int m_score;

function automatic int ref_points(logic [5:0] c);
    if (c[3:0] >= 13)
        return 50;              // wild, wild draw four
    else if (c[3:0] >= 10)
        return 20;
    return c[3:0];
endfunction

function automatic void model_clear();
    for (int c = 0; c < 4; c++) begin
        for (int v = 0; v < 13; v++) begin
            m_cnt[c][v] = 0;
        end
    end
    m_wild  = 0;
    m_wild4 = 0;
    m_num   = 0;
    m_score = 0;
endfunction

function automatic int model_copies(logic [5:0] c);
    if (c[3:0] == 13)
        return m_wild;
    else if (c[3:0] == 14)
        return m_wild4;
    return m_cnt[c[5:4]][c[3:0]];
endfunction

// d is +1 for a card taken, -1 for a card played
function automatic void model_change(logic [5:0] c, int d);
    if (c[3:0] == 13)
        m_wild += d;
    else if (c[3:0] == 14)
        m_wild4 += d;
    else
        m_cnt[c[5:4]][c[3:0]] += d;
    m_num   += d;
    m_score += d * ref_points(c);
endfunction

function automatic bit ref_pick(input logic [5:0] prev, output logic [5:0] card);
    int pc;
    int pv;
    int first;
    pc    = prev[5:4];
    pv    = prev[3:0];
    first = 0;                  // red with no colored card
    card  = '0;
    for (int c = 3; c >= 0; c--) begin
        for (int v = 0; v < 13; v++) begin
            if (m_cnt[c][v] > 0)
                first = c;
        end
    end
    for (int v = 0; v < 13; v++) begin
        if (m_cnt[pc][v] > 0) begin
            card = 6'(pc * 16 + v);
            return 1'b1;
        end
    end
    if (pv < 13) begin
        for (int c = 0; c < 4; c++) begin
            if (m_cnt[c][pv] > 0) begin
                card = 6'(c * 16 + pv);
                return 1'b1;
            end
        end
    end
    if (m_wild > 0 || m_wild4 > 0) begin
        card = 6'(first * 16 + (m_wild > 0 ? 13 : 14));
        return 1'b1;
    end
    return 1'b0;
endfunction

`endif

/* tb_uno_player.sv */
`timescale 1ns/1ps

module tb_uno_player import uno_pkg::*; ();

    localparam int COPY_W    = 3;
    localparam int MAX_COPY  = (1 << COPY_W) - 1;
    localparam int NUM_TESTS = 6;
    localparam int WAIT_MAX  = 50;

    logic i_clk, i_rst_n, i_init, i_start;
    logic i_draw_two, i_draw_four, i_drawn, i_check;
    logic [5:0] i_prev_card;
    logic [5:0] i_drawn_card;
    logic o_out, o_draw_card;
    logic [5:0] o_out_card;
    logic [HAND_W-1:0]  o_hand_num;
    logic [SCORE_W-1:0] o_score;

    integer seed;
    int n_checks, n_errors, n_tests, n_failed, test_err0;
    string test_name;
    bit exp_play;
    logic [5:0] exp_card;
    int exp_num, exp_score;
    logic [5:0] deal_q[$];
    logic [5:0] pen_q[$];
    logic [5:0] nocard_card;
    logic out_q = 1'b0;

    `include "tb_uno_model.svh"

    uno_player #(.COPY_W(COPY_W)) u_uno_player (.*);

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    initial begin
        repeat (NUM_TESTS * 200) @(posedge i_clk);
        $display("timeout: run did not finish within %0d cycles", NUM_TESTS * 200);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    // played card on o_out rising and hand totals on every acknowledge
    always @(posedge i_clk) begin
        if (i_rst_n && o_out && !out_q) begin
            if (exp_play) begin
                check_value("o_out_card", exp_card, o_out_card);
            end else begin
                n_errors++;
                $display("ERROR at %0t: o_out rose in a turn with no playable card", $time);
            end
        end
        if (i_rst_n && i_check) begin
            check_value("o_hand_num", exp_num, o_hand_num);
            check_value("o_score", exp_score, o_score);
        end
        out_q <= o_out;
    end

    // a copy count of 2 or more is skipped since one turn adds at most 5
    function automatic logic [5:0] rand_card();
        logic [5:0] c;
        do begin
            c[5:4] = 2'($random(seed));
            c[3:0] = 4'($unsigned($random(seed)) % 15);
        end while (model_copies(c) >= MAX_COPY - 5);
        return c;
    endfunction

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = n_errors;
        n_tests++;
    endtask

    task automatic end_test();
        if (n_errors != test_err0)
            n_failed++;
        $display("test %0d %s: %s", n_tests, test_name, (n_errors == test_err0) ? "ok" : "FAILED");
    endtask

    task automatic apply_reset();
        i_rst_n = 1'b0;
        repeat (4) @(negedge i_clk);
        i_rst_n = 1'b1;
        model_clear();
    endtask

    task automatic give_card(input logic [5:0] c, input int gap);
        repeat (gap) @(negedge i_clk);
        i_drawn      = 1'b1;
        i_drawn_card = c;
        @(negedge i_clk);
        i_drawn = 1'b0;
    endtask

    task automatic deal_hand();
        i_init = 1'b1;
        @(negedge i_clk);
        i_init = 1'b0;
        foreach (deal_q[i]) begin
            model_change(deal_q[i], 1);
            give_card(deal_q[i], 0);
        end
        check_value("o_hand_num", m_num, o_hand_num);
        check_value("o_score", m_score, o_score);
        deal_q.delete();
    endtask

    task automatic wait_result(output bit got_out);
        int n;
        n = 0;
        while (!o_out && !o_draw_card && n < WAIT_MAX) begin
            @(negedge i_clk);
            n++;
        end
        got_out = o_out;
        if (!o_out && !o_draw_card) begin
            n_errors++;
            $display("ERROR at %0t: neither o_out nor o_draw_card rose in %0d cycles",
                     $time, WAIT_MAX);
        end
    endtask

    // penalty cards come from pen_q and a no-card draw gets nocard_card
    task automatic run_turn(input logic [5:0] prev, input int gap_max);
        logic [5:0] pick;
        bit got_out;
        foreach (pen_q[i]) model_change(pen_q[i], 1);
        exp_play = ref_pick(prev, pick);
        exp_card = pick;
        if (exp_play)
            model_change(pick, -1);
        else
            model_change(nocard_card, 1);
        exp_num     = m_num;
        exp_score   = m_score;
        i_prev_card = prev;
        i_start     = 1'b1;
        i_draw_two  = pen_q.size() == 2;
        i_draw_four = pen_q.size() == 4;
        @(negedge i_clk);
        i_draw_two  = 1'b0;
        i_draw_four = 1'b0;
        foreach (pen_q[i]) give_card(pen_q[i], $unsigned($random(seed)) % (gap_max + 1));
        pen_q.delete();
        wait_result(got_out);
        if (got_out != exp_play) begin
            n_errors++;
            $display("ERROR at %0t: o_out=%0b o_draw_card=%0b but the model %s", $time,
                     o_out, o_draw_card, exp_play ? "expects a play" : "expects a draw");
        end else if (!got_out) begin
            give_card(nocard_card, $unsigned($random(seed)) % (gap_max + 1));
            repeat (2) @(negedge i_clk);    // drawn card stays in the hand
        end
        i_check = 1'b1;
        @(negedge i_clk);
        i_check = 1'b0;
        i_start = 1'b0;
    endtask

    initial begin
        logic [5:0] prev;
        int r;
        seed         = 32'h4df2;
        i_rst_n      = 1'b0;
        i_init       = 1'b0;
        i_start      = 1'b0;
        i_draw_two   = 1'b0;
        i_draw_four  = 1'b0;
        i_prev_card  = '0;
        i_drawn      = 1'b0;
        i_drawn_card = '0;
        i_check      = 1'b0;
        apply_reset();

        begin_test("reset and deal");
        check_value("o_out", 0, o_out);
        check_value("o_draw_card", 0, o_draw_card);
        check_value("o_out_card", 0, o_out_card);
        check_value("o_hand_num", 0, o_hand_num);
        check_value("o_score", 0, o_score);
        repeat (INIT_HAND) deal_q.push_back(rand_card());
        deal_hand();
        end_test();

        // upper hex digit is the color and lower the value
        begin_test("color match");
        apply_reset();
        deal_q = '{6'h05, 6'h02, 6'h17, 6'h23, 6'h39, 6'h0d, 6'h0b};
        deal_hand();
        run_turn(6'h08, 0);
        end_test();

        begin_test("number match");
        apply_reset();
        deal_q = '{6'h14, 6'h24, 6'h01, 6'h19, 6'h2c, 6'h07, 6'h0e};
        deal_hand();
        run_turn(6'h34, 0);
        end_test();

        begin_test("wild play");
        apply_reset();
        deal_q = '{6'h12, 6'h38, 6'h1b, 6'h0d, 6'h3e, 6'h31, 6'h13};
        deal_hand();
        run_turn(6'h26, 0);     // plain wild first
        run_turn(6'h26, 0);     // then wild draw four
        end_test();

        begin_test("no playable card");
        apply_reset();
        deal_q = '{6'h01, 6'h03, 6'h12, 6'h38, 6'h1b, 6'h07, 6'h30};
        deal_hand();
        nocard_card = 6'h26;    // playable, but kept for later
        run_turn(6'h26, 0);
        end_test();

        begin_test("random penalty turns");
        apply_reset();
        repeat (INIT_HAND) deal_q.push_back(rand_card());
        deal_hand();
        repeat (30) begin
            r = $unsigned($random(seed)) % 6;
            repeat ((r < 2) ? 2 : (r == 2) ? 4 : 0) pen_q.push_back(rand_card());
            nocard_card = rand_card();
            prev[5:4]   = 2'($random(seed));
            prev[3:0]   = 4'($unsigned($random(seed)) % 15);
            run_turn(prev, 2);
        end
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* uno_card_picker.sv */
`timescale 1ns/1ps

module uno_card_picker import uno_pkg::*; (
    input  card_t                                 i_prev_card,
    input  logic [NUM_COLORS-1:0]                 i_color_has,
    input  logic [NUM_VALUES-1:0]                 i_value_has,
    input  logic                                  i_wild_has,
    input  logic                                  i_wild4_has,
    input  logic [NUM_COLORS-1:0][NUM_VALUES-1:0] i_copies,
    output pick_kind_e                            o_kind,
    output card_t                                 o_card
);

    color_e     pc;
    logic [3:0] pv;
    logic [3:0] col_val;     // lowest value held in prev color
    color_e     num_color;   // first color holding prev value
    color_e     wild_color;

    assign pc = i_prev_card.color;
    assign pv = i_prev_card.value;

    // scan downwards so the lowest hit wins
    always_comb begin
        col_val = '0;
        for (int v = NUM_VALUES - 1; v >= 0; v--) begin
            if (i_copies[pc][v])
                col_val = 4'(v);
        end
    end

    always_comb begin
        num_color = RED;
        if (pv < NUM_VALUES) begin
            for (int c = NUM_COLORS - 1; c >= 0; c--) begin
                if (i_copies[c][pv])
                    num_color = color_e'(c);
            end
        end
    end

    // red when no colored card is left
    always_comb begin
        wild_color = RED;
        for (int c = NUM_COLORS - 1; c >= 0; c--) begin
            if (i_color_has[c])
                wild_color = color_e'(c);
        end
    end

    always_comb begin
        o_kind = PICK_NONE;
        o_card = '0;
        if (i_color_has[pc]) begin
            o_kind       = PICK_COLOR;
            o_card.color = pc;
            o_card.value = col_val;
        end else if (pv < NUM_VALUES && i_value_has[pv]) begin
            o_kind       = PICK_NUMBER;
            o_card.color = num_color;
            o_card.value = pv;
        end else if (i_wild_has) begin
            o_kind       = PICK_WILD;
            o_card.color = wild_color;
            o_card.value = VAL_WILD;
        end else if (i_wild4_has) begin
            o_kind       = PICK_WILD4;
            o_card.color = wild_color;
            o_card.value = VAL_WILD4;
        end
    end

endmodule

/* uno_hand_if.sv */
`timescale 1ns/1ps

interface uno_hand_if import uno_pkg::*; ();

    // add / remove strobes, never both in one cycle
    logic  add_en;
    card_t add_card;
    logic  rem_en;
    card_t rem_card;

    // presence view of the hand
    logic [NUM_COLORS-1:0]                 color_has;
    logic [NUM_VALUES-1:0]                 value_has;  // value held in any color
    logic                                  wild_has;
    logic                                  wild4_has;
    logic [NUM_COLORS-1:0][NUM_VALUES-1:0] copies;

    modport ctrl (
        output add_en,
        output add_card,
        output rem_en,
        output rem_card,
        input  color_has,
        input  value_has,
        input  wild_has,
        input  wild4_has,
        input  copies
    );

    modport store (
        input  add_en,
        input  add_card,
        input  rem_en,
        input  rem_card,
        output color_has,
        output value_has,
        output wild_has,
        output wild4_has,
        output copies
    );

endinterface

/* uno_hand_store.sv */
`timescale 1ns/1ps

module uno_hand_store import uno_pkg::*; #(
    parameter int COPY_W = 3
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    uno_hand_if.store          hand,
    output logic [HAND_W-1:0]  o_hand_num,
    output logic [SCORE_W-1:0] o_score
);

    logic [COPY_W-1:0] cnt [NUM_COLORS][NUM_VALUES];
    logic [COPY_W-1:0] wild_cnt;
    logic [COPY_W-1:0] wild4_cnt;

    logic               add_ok;
    logic               add_col;
    logic               rem_col;
    logic [SCORE_W-1:0] add_pts;
    logic [SCORE_W-1:0] rem_pts;

    // value 15 is not a card, ignore it
    assign add_ok  = hand.add_card.value <= VAL_WILD4;
    assign add_col = hand.add_card.value < NUM_VALUES;
    assign rem_col = hand.rem_card.value < NUM_VALUES;
    assign add_pts = card_points(hand.add_card);
    assign rem_pts = card_points(hand.rem_card);

    // copy counters
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int c = 0; c < NUM_COLORS; c++) begin
                for (int v = 0; v < NUM_VALUES; v++) begin
                    cnt[c][v] <= '0;
                end
            end
            wild_cnt  <= '0;
            wild4_cnt <= '0;
        end else if (hand.add_en) begin
            if (hand.add_card.value == VAL_WILD)
                wild_cnt <= wild_cnt + 1'b1;
            else if (hand.add_card.value == VAL_WILD4)
                wild4_cnt <= wild4_cnt + 1'b1;
            else if (add_col)
                cnt[hand.add_card.color][hand.add_card.value] <=
                    cnt[hand.add_card.color][hand.add_card.value] + 1'b1;
        end else if (hand.rem_en) begin
            // a played wild carries its chosen color, counter is shared
            if (hand.rem_card.value == VAL_WILD)
                wild_cnt <= wild_cnt - 1'b1;
            else if (hand.rem_card.value == VAL_WILD4)
                wild4_cnt <= wild4_cnt - 1'b1;
            else if (rem_col)
                cnt[hand.rem_card.color][hand.rem_card.value] <=
                    cnt[hand.rem_card.color][hand.rem_card.value] - 1'b1;
        end
    end

    // hand size and score follow every add / remove
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hand_num <= '0;
            o_score    <= '0;
        end else if (hand.add_en && add_ok) begin
            o_hand_num <= o_hand_num + 1'b1;
            o_score    <= o_score + add_pts;
        end else if (hand.rem_en) begin
            o_hand_num <= o_hand_num - 1'b1;
            o_score    <= o_score - rem_pts;
        end
    end

    always_comb begin
        for (int c = 0; c < NUM_COLORS; c++) begin
            for (int v = 0; v < NUM_VALUES; v++) begin
                hand.copies[c][v] = |cnt[c][v];
            end
        end
        for (int c = 0; c < NUM_COLORS; c++) begin
            hand.color_has[c] = |hand.copies[c];
        end
        for (int v = 0; v < NUM_VALUES; v++) begin
            hand.value_has[v] = 1'b0;
            for (int c = 0; c < NUM_COLORS; c++) begin
                hand.value_has[v] = hand.value_has[v] | hand.copies[c][v];
            end
        end
    end

    assign hand.wild_has  = |wild_cnt;
    assign hand.wild4_has = |wild4_cnt;

endmodule

/* uno_pkg.sv */
package uno_pkg;

    typedef enum logic [1:0] {
        RED    = 2'd0,
        YELLOW = 2'd1,
        GREEN  = 2'd2,
        BLUE   = 2'd3
    } color_e;

    typedef struct packed {
        color_e     color;
        logic [3:0] value;
    } card_t;

    localparam int NUM_COLORS = 4;
    localparam int NUM_VALUES = 13;       // colored values per color

    localparam logic [3:0] VAL_ACTION_MIN = 4'd10;
    localparam logic [3:0] VAL_WILD       = 4'd13;
    localparam logic [3:0] VAL_WILD4      = 4'd14;

    localparam int PTS_ACTION = 20;
    localparam int PTS_WILD   = 50;

    localparam int HAND_W    = 7;
    localparam int SCORE_W   = 11;
    localparam int INIT_HAND = 7;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DRAW,
        ST_THINK,
        ST_OUT,
        ST_NOCARD,
        ST_ACK
    } turn_state_e;

    typedef enum logic [2:0] {
        PICK_COLOR,
        PICK_NUMBER,
        PICK_WILD,
        PICK_WILD4,
        PICK_NONE
    } pick_kind_e;

    // points a card is worth in the hand score
    function automatic logic [SCORE_W-1:0] card_points(card_t c);
        if (c.value >= VAL_WILD)
            return SCORE_W'(PTS_WILD);
        else if (c.value >= VAL_ACTION_MIN)
            return SCORE_W'(PTS_ACTION);
        else
            return SCORE_W'(c.value);
    endfunction

endpackage

/* uno_player.sv */
`timescale 1ns/1ps

module uno_player import uno_pkg::*; #(
    parameter int COPY_W = 3
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_init,
    input  logic               i_start,
    input  logic               i_draw_two,
    input  logic               i_draw_four,
    input  card_t              i_prev_card,
    input  logic               i_drawn,
    input  card_t              i_drawn_card,
    input  logic               i_check,
    output logic               o_out,
    output card_t              o_out_card,
    output logic               o_draw_card,
    output logic [HAND_W-1:0]  o_hand_num,
    output logic [SCORE_W-1:0] o_score
);

    uno_hand_if u_hand_if ();

    uno_hand_store #(
        .COPY_W (COPY_W)
    ) u_hand_store (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .hand       (u_hand_if.store),
        .o_hand_num (o_hand_num),
        .o_score    (o_score)
    );

    uno_turn_fsm u_turn_fsm (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_init       (i_init),
        .i_start      (i_start),
        .i_draw_two   (i_draw_two),
        .i_draw_four  (i_draw_four),
        .i_prev_card  (i_prev_card),
        .i_drawn      (i_drawn),
        .i_drawn_card (i_drawn_card),
        .i_check      (i_check),
        .hand         (u_hand_if.ctrl),
        .o_out        (o_out),
        .o_out_card   (o_out_card),
        .o_draw_card  (o_draw_card)
    );

endmodule

/* uno_turn_fsm.sv */
`timescale 1ns/1ps

module uno_turn_fsm import uno_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_init,
    input  logic    i_start,
    input  logic    i_draw_two,
    input  logic    i_draw_four,
    input  card_t   i_prev_card,
    input  logic    i_drawn,
    input  card_t   i_drawn_card,
    input  logic    i_check,
    uno_hand_if.ctrl hand,
    output logic    o_out,
    output card_t   o_out_card,
    output logic    o_draw_card
);

    turn_state_e state;
    turn_state_e state_nxt;
    logic [2:0]  draw_left;      // cards still to take
    logic [2:0]  draw_left_nxt;
    pick_kind_e  pick_kind;
    card_t       pick_card;
    logic        play;

    uno_card_picker u_picker (
        .i_prev_card (i_prev_card),
        .i_color_has (hand.color_has),
        .i_value_has (hand.value_has),
        .i_wild_has  (hand.wild_has),
        .i_wild4_has (hand.wild4_has),
        .i_copies    (hand.copies),
        .o_kind      (pick_kind),
        .o_card      (pick_card)
    );

    assign play = (state == ST_THINK) && (pick_kind != PICK_NONE);

    always_comb begin
        state_nxt     = state;
        draw_left_nxt = draw_left;
        hand.add_en   = 1'b0;
        hand.add_card = i_drawn_card;
        hand.rem_en   = 1'b0;
        hand.rem_card = pick_card;
        case (state)
            ST_IDLE: begin
                if (i_start) begin
                    if (i_draw_two) begin
                        draw_left_nxt = 3'd2;
                        state_nxt     = ST_DRAW;
                    end else if (i_draw_four) begin
                        draw_left_nxt = 3'd4;
                        state_nxt     = ST_DRAW;
                    end else begin
                        state_nxt = ST_THINK;
                    end
                end else if (i_init) begin
                    draw_left_nxt = 3'(INIT_HAND);
                    state_nxt     = ST_DRAW;
                end
            end
            ST_DRAW: begin
                if (i_drawn) begin
                    hand.add_en = 1'b1;
                    if (draw_left == 3'd1) begin
                        draw_left_nxt = '0;
                        state_nxt     = i_start ? ST_THINK : ST_IDLE; // deal may end a turn
                    end else begin
                        draw_left_nxt = draw_left - 3'd1;
                    end
                end
            end
            ST_THINK: begin
                hand.rem_en = play;
                state_nxt   = play ? ST_OUT : ST_NOCARD;
            end
            ST_OUT: begin
                if (i_check)
                    state_nxt = ST_IDLE;
            end
            ST_NOCARD: begin
                if (i_drawn) begin
                    hand.add_en = 1'b1; // kept for a later turn
                    state_nxt   = ST_ACK;
                end
            end
            ST_ACK: begin
                if (i_check)
                    state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= ST_IDLE;
            draw_left <= '0;
        end else begin
            state     <= state_nxt;
            draw_left <= draw_left_nxt;
        end
    end

    // held until the next play
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_out_card <= '0;
        else if (play)
            o_out_card <= pick_card;
    end

    assign o_out       = state == ST_OUT;
    assign o_draw_card = state == ST_NOCARD;

endmodule

/* vlog.f */
+incdir+.
uno_pkg.sv
uno_hand_if.sv
uno_hand_store.sv
uno_card_picker.sv
uno_turn_fsm.sv
uno_player.sv
tb_uno_player.sv
